// ==== fetch_params.svh ====
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// Width of data words and of addresses
`define FETCH_XLEN 32

// Index bits of the direct-mapped instruction cache, one word per line
`define FETCH_INDEX_BITS 4

// First fetch address after reset
`define FETCH_RESET_PC 32'h0000_0000

// Width of the running sequence tag in each packet
`define FETCH_TAG_BITS 8

`endif

// ==== fetch_pkg.sv ====
`default_nettype none

`include "fetch_params.svh"

package fetch_pkg;

	// Data and address word
	typedef logic [`FETCH_XLEN-1:0] word_t;

	// Instructions are always 32 bits, no compressed forms
	typedef logic [31:0] instr_t;

	// Packet sequence number, wraps around
	typedef logic [`FETCH_TAG_BITS-1:0] fetch_tag_t;

	// Line index, pc bits just above the byte offset
	typedef logic [`FETCH_INDEX_BITS-1:0] cache_index_t;

	// Address bits above the index
	typedef logic [`FETCH_XLEN-`FETCH_INDEX_BITS-3:0] cache_tag_t;

	typedef enum logic {
		fetch_run,
		fetch_wait_jump
	} fetch_state_t;

	typedef enum logic {
		refill_idle,
		refill_bus
	} refill_state_t;

endpackage

`default_nettype wire

// ==== fetch_csr.sv ====
`default_nettype none

`include "fetch_params.svh"

module fetch_csr
	import fetch_pkg::*;
(
	input wire i_clock,
	input wire i_reset,

	// Configuration write port
	input wire i_cfg_write,
	input wire i_cfg_addr,
	input wire word_t i_cfg_wdata,

	// Interrupt
	input wire i_irq_line,
	input wire i_irq_dispatched,
	output word_t o_irq_vector,
	output logic o_irq_pending
);
	logic irq_enable;
	logic irq_line_d;
	logic irq_rise;

	assign irq_rise = i_irq_line && !irq_line_d;

	// Address 0 is the vector, address 1 bit 0 the enable
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_irq_vector <= `FETCH_RESET_PC;
			irq_enable <= 1'b0;
		end else if (i_cfg_write) begin
			if (i_cfg_addr)
				irq_enable <= i_cfg_wdata[0];
			else
				o_irq_vector <= i_cfg_wdata;
		end
	end

	// A new edge wins over the clear of the previous one
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			irq_line_d <= 1'b0;
			o_irq_pending <= 1'b0;
		end else begin
			irq_line_d <= i_irq_line;
			if (irq_rise && irq_enable)
				o_irq_pending <= 1'b1;
			else if (i_irq_dispatched)
				o_irq_pending <= 1'b0;
		end
	end

	// Fetch only dispatches an interrupt that was pending
	a_dispatch_needs_pending: assert property (@(posedge i_clock) disable iff (i_reset)
		i_irq_dispatched |-> $past(o_irq_pending));

endmodule

`default_nettype wire

// ==== predecode.sv ====
`default_nettype none

`include "fetch_params.svh"

module predecode
	import fetch_pkg::*;
(
	input wire instr_t i_instr,
	output logic o_is_transfer
);
	localparam logic [6:0] op_jal = 7'b1101111;
	localparam logic [6:0] op_jalr = 7'b1100111;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_system = 7'b1110011;
	localparam logic [11:0] funct12_mret = 12'h302;
	localparam logic [11:0] funct12_wfi = 12'h105;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [11:0] funct12;
	logic regs_zero;
	logic is_jal;
	logic is_jalr;
	logic is_branch;
	logic is_mret;
	logic is_wfi;

	assign opcode = i_instr[6:0];
	assign funct3 = i_instr[14:12];
	assign funct12 = i_instr[31:20];

	// rd and rs1 are both x0 in the privileged encodings
	assign regs_zero = (i_instr[11:7] == 5'd0) && (i_instr[19:15] == 5'd0);

	assign is_jal = (opcode == op_jal);
	assign is_jalr = (opcode == op_jalr) && (funct3 == 3'b000);

	// funct3 010 and 011 are not branch conditions
	assign is_branch = (opcode == op_branch) && (funct3[2:1] != 2'b01);

	assign is_mret = (opcode == op_system) && (funct3 == 3'b000) && regs_zero
		&& (funct12 == funct12_mret);
	assign is_wfi = (opcode == op_system) && (funct3 == 3'b000) && regs_zero
		&& (funct12 == funct12_wfi);

	assign o_is_transfer = is_jal || is_jalr || is_branch || is_mret || is_wfi;

endmodule

`default_nettype wire

// ==== icache.sv ====
`default_nettype none

`include "fetch_params.svh"

module icache
	import fetch_pkg::*;
(
	input wire i_clock,
	input wire i_reset,

	// Fetch side
	input wire word_t i_pc,
	input wire i_stall,
	output logic o_ready,
	output instr_t o_rdata,

	// Memory bus
	output logic o_bus_request,
	output word_t o_bus_address,
	input wire i_bus_ready,
	input wire word_t i_bus_rdata
);
	localparam int lines = 1 << `FETCH_INDEX_BITS;

	logic valid_mem [lines];
	cache_tag_t tag_mem [lines];
	instr_t data_mem [lines];

	refill_state_t state;
	cache_index_t pc_index;
	cache_tag_t pc_tag;
	cache_index_t fill_index;
	cache_tag_t fill_tag;
	logic hit;
	logic start_refill;
	logic fill_done;

	assign pc_index = i_pc[`FETCH_INDEX_BITS+1:2];
	assign pc_tag = i_pc[`FETCH_XLEN-1:`FETCH_INDEX_BITS+2];

	// The line being filled comes from the latched address, the pc may move meanwhile
	assign fill_index = o_bus_address[`FETCH_INDEX_BITS+1:2];
	assign fill_tag = o_bus_address[`FETCH_XLEN-1:`FETCH_INDEX_BITS+2];

	assign hit = valid_mem[pc_index] && (tag_mem[pc_index] == pc_tag);
	assign o_ready = hit;
	assign o_rdata = data_mem[pc_index];

	assign start_refill = (state == refill_idle) && !hit && !i_stall;
	assign fill_done = (state == refill_bus) && i_bus_ready;

	// Refill FSM
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= refill_idle;
			o_bus_request <= 1'b0;
		end else begin
			case (state)
				refill_idle: begin
					if (start_refill) begin
						state <= refill_bus;
						o_bus_request <= 1'b1;
					end
				end
				refill_bus: begin
					// Word arrives with ready, request drops next cycle
					if (i_bus_ready) begin
						state <= refill_idle;
						o_bus_request <= 1'b0;
					end
				end
				default: begin
					state <= refill_idle;
					o_bus_request <= 1'b0;
				end
			endcase
		end
	end

	// Word-aligned miss address, held for the whole request
	always_ff @(posedge i_clock) begin
		if (start_refill)
			o_bus_address <= {i_pc[`FETCH_XLEN-1:2], 2'b00};
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			for (int i = 0; i < lines; i++) begin
				valid_mem[i] <= 1'b0;
			end
		end else if (fill_done) begin
			valid_mem[fill_index] <= 1'b1;
		end
	end

	always_ff @(posedge i_clock) begin
		if (fill_done) begin
			tag_mem[fill_index] <= fill_tag;
			data_mem[fill_index] <= i_bus_rdata;
		end
	end

	// Address may not move while memory has not answered
	a_address_stable: assert property (@(posedge i_clock) disable iff (i_reset)
		(o_bus_request && !i_bus_ready) |=> $stable(o_bus_address));

	a_no_request_idle: assert property (@(posedge i_clock) disable iff (i_reset)
		(state == refill_idle) |-> !o_bus_request);

endmodule

`default_nettype wire

// ==== fetch_unit.sv ====
`default_nettype none

`include "fetch_params.svh"

module fetch_unit
	import fetch_pkg::*;
(
	input wire i_clock,
	input wire i_reset,

	// Execute
	input wire i_jump,
	input wire word_t i_jump_pc,

	// Interrupt
	input wire i_irq_pending,
	input wire word_t i_irq_vector,
	output logic o_irq_dispatched,
	output word_t o_irq_epc,

	// Cache and predecode
	output word_t o_pc,
	output logic o_cache_stall,
	input wire i_cache_ready,
	input wire instr_t i_cache_rdata,
	input wire i_is_transfer,

	// Decode
	input wire i_decode_busy,
	output logic o_valid,
	output word_t o_packet_pc,
	output instr_t o_instr,
	output fetch_tag_t o_tag
);
	fetch_state_t state;
	word_t pc;
	fetch_tag_t next_tag;
	logic take_irq;
	logic load;

	assign o_pc = pc;

	// No refill while the packet is held or while waiting for a jump
	assign o_cache_stall = i_decode_busy || (state == fetch_wait_jump);

	// The latch in the configuration block clears one cycle after the pulse,
	// so a dispatch in flight must not take the same interrupt twice
	assign take_irq = i_irq_pending && !o_irq_dispatched && !i_decode_busy;

	assign load = (state == fetch_run) && i_cache_ready && !i_decode_busy && !take_irq;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= fetch_run;
			pc <= `FETCH_RESET_PC;
			next_tag <= '0;
			o_tag <= '0;
			o_valid <= 1'b0;
			o_irq_dispatched <= 1'b0;
		end else begin
			o_irq_dispatched <= 1'b0;
			// Packet is consumed on any edge where decode is free
			if (!i_decode_busy)
				o_valid <= 1'b0;

			if (take_irq) begin
				o_irq_dispatched <= 1'b1;
				pc <= i_irq_vector;
				state <= fetch_run;
			end else if (load) begin
				o_valid <= 1'b1;
				o_tag <= next_tag;
				next_tag <= next_tag + fetch_tag_t'(1);
				// Transfer keeps its own pc until execute sends the target
				if (i_is_transfer)
					state <= fetch_wait_jump;
				else
					pc <= pc + word_t'(4);
			end else if ((state == fetch_wait_jump) && i_jump) begin
				// Jump pulse is taken even under busy so it is never lost
				pc <= i_jump_pc;
				state <= fetch_run;
			end
		end
	end

	// Packet payload and return address
	always_ff @(posedge i_clock) begin
		if (load) begin
			o_packet_pc <= pc;
			o_instr <= i_cache_rdata;
		end
		if (take_irq)
			o_irq_epc <= pc;
	end

	// Decode sees the same packet until it takes it
	a_packet_hold: assert property (@(posedge i_clock) disable iff (i_reset)
		(o_valid && i_decode_busy) |=> (o_valid && $stable(o_packet_pc)
		&& $stable(o_instr) && $stable(o_tag)));

endmodule

`default_nettype wire

// ==== fetch_top.sv ====
`default_nettype none

`include "fetch_params.svh"

module fetch_top
	import fetch_pkg::*;
(
	input wire i_clock,
	input wire i_reset,

	// Configuration
	input wire i_cfg_write,
	input wire i_cfg_addr,
	input wire word_t i_cfg_wdata,
	input wire i_irq_line,

	// Execute
	input wire i_jump,
	input wire word_t i_jump_pc,

	// Memory bus
	output logic o_bus_request,
	output word_t o_bus_address,
	input wire i_bus_ready,
	input wire word_t i_bus_rdata,

	// Decode
	input wire i_decode_busy,
	output logic o_valid,
	output word_t o_pc,
	output instr_t o_instr,
	output fetch_tag_t o_tag,
	output logic o_irq_dispatched,
	output word_t o_irq_epc
);
	word_t fetch_pc;
	word_t irq_vector;
	instr_t cache_rdata;
	logic cache_ready;
	logic cache_stall;
	logic is_transfer;
	logic irq_pending;

	fetch_csr u_csr (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_cfg_write(i_cfg_write),
		.i_cfg_addr(i_cfg_addr),
		.i_cfg_wdata(i_cfg_wdata),
		.i_irq_line(i_irq_line),
		.i_irq_dispatched(o_irq_dispatched),
		.o_irq_vector(irq_vector),
		.o_irq_pending(irq_pending)
	);

	icache u_icache (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_pc(fetch_pc),
		.i_stall(cache_stall),
		.o_ready(cache_ready),
		.o_rdata(cache_rdata),
		.o_bus_request(o_bus_request),
		.o_bus_address(o_bus_address),
		.i_bus_ready(i_bus_ready),
		.i_bus_rdata(i_bus_rdata)
	);

	// Classifies the word the cache returns for the current pc
	predecode u_predecode (
		.i_instr(cache_rdata),
		.o_is_transfer(is_transfer)
	);

	fetch_unit u_fetch (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_jump(i_jump),
		.i_jump_pc(i_jump_pc),
		.i_irq_pending(irq_pending),
		.i_irq_vector(irq_vector),
		.o_irq_dispatched(o_irq_dispatched),
		.o_irq_epc(o_irq_epc),
		.o_pc(fetch_pc),
		.o_cache_stall(cache_stall),
		.i_cache_ready(cache_ready),
		.i_cache_rdata(cache_rdata),
		.i_is_transfer(is_transfer),
		.i_decode_busy(i_decode_busy),
		.o_valid(o_valid),
		.o_packet_pc(o_pc),
		.o_instr(o_instr),
		.o_tag(o_tag)
	);

endmodule

`default_nettype wire

// ==== tb_fetch.sv ====
`default_nettype none

`include "fetch_params.svh"

module tb_fetch
	import fetch_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam word_t vector_pc = 32'h0000_0140;
	localparam int wait_limit = 200;

	logic i_clock;
	logic i_reset;
	logic i_cfg_write;
	logic i_cfg_addr;
	word_t i_cfg_wdata;
	logic i_irq_line;
	logic i_jump;
	word_t i_jump_pc;
	logic o_bus_request;
	word_t o_bus_address;
	logic i_bus_ready;
	word_t i_bus_rdata;
	logic i_decode_busy;
	logic o_valid;
	word_t o_pc;
	instr_t o_instr;
	fetch_tag_t o_tag;
	logic o_irq_dispatched;
	word_t o_irq_epc;

	integer seed;
	int bus_wait;

	// Reference model, private to the monitor
	word_t exp_pc;
	fetch_tag_t exp_tag;
	logic waiting;
	logic hold_check;
	word_t held_pc;
	instr_t held_instr;
	fetch_tag_t held_tag;

	// Handshake between monitor and stimulus
	logic jump_wait_seen;
	int packet_count;
	int dispatch_count;
	logic irq_allowed;
	logic no_bus_check;

	fetch_top uut (.*);

	always #10 i_clock = ~i_clock;

	function automatic logic is_jal_addr(input word_t addr);
		return ((addr >> 2) % 32'd7) == 32'd6;
	endfunction

	// addi with the address folded into its fields, jal on every seventh word
	function automatic instr_t memory_word(input word_t addr);
		if (is_jal_addr(addr))
			return {addr[21:2] ^ {10'd0, addr[31:22]}, 5'd1, 7'b1101111};
		else
			return {addr[13:2] ^ addr[31:20], addr[18:14], 3'b000, addr[23:19], 7'b0010011};
	endfunction

	task automatic stop_run(input string what);
		$display("%s", what);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input word_t got, input word_t expected);
		assert (got == expected) else
			stop_run($sformatf("Mismatch at %0t ns: %s got %h expected %h",
				$time, name, got, expected));
	endtask

	// Decode back-pressure and memory responses
	always @(posedge i_clock) begin
		if (i_reset) begin
			i_decode_busy <= 1'b0;
			i_bus_ready <= 1'b0;
		end else begin
			i_decode_busy <= ($unsigned($random(seed)) % 10) < 3;
			if (i_bus_ready) begin
				i_bus_ready <= 1'b0;
			end else if (o_bus_request) begin
				if (bus_wait < 0)
					bus_wait = $unsigned($random(seed)) % 4;
				if (bus_wait == 0) begin
					i_bus_ready <= 1'b1;
					i_bus_rdata <= memory_word(o_bus_address);
				end
				bus_wait = bus_wait - 1;
			end
		end
	end

	// Packet, jump and interrupt monitor
	always @(posedge i_clock) begin
		if (i_reset) begin
			exp_pc = `FETCH_RESET_PC;
			exp_tag = '0;
			waiting = 1'b0;
			hold_check = 1'b0;
		end else begin
			if (hold_check) begin
				check_value("o_valid", word_t'(o_valid), 32'd1);
				check_value("o_pc", o_pc, held_pc);
				check_value("o_instr", o_instr, held_instr);
				check_value("o_tag", word_t'(o_tag), word_t'(held_tag));
			end
			hold_check = o_valid && i_decode_busy;
			held_pc = o_pc;
			held_instr = o_instr;
			held_tag = o_tag;
			if (o_valid && !i_decode_busy) begin
				assert (!waiting) else stop_run("Packet delivered while waiting for a jump");
				check_value("o_pc", o_pc, exp_pc);
				check_value("o_instr", o_instr, memory_word(exp_pc));
				check_value("o_tag", word_t'(o_tag), word_t'(exp_tag));
				waiting = is_jal_addr(exp_pc);
				exp_pc = exp_pc + 32'd4;
				exp_tag = exp_tag + fetch_tag_t'(1);
				packet_count <= packet_count + 1;
			end
			if (i_jump) begin
				exp_pc = i_jump_pc;
				waiting = 1'b0;
			end
			if (o_irq_dispatched) begin
				assert (irq_allowed) else stop_run("Interrupt dispatched while disabled");
				assert (!waiting) else stop_run("Interrupt dispatched during a jump wait");
				check_value("o_irq_epc", o_irq_epc, exp_pc);
				exp_pc = vector_pc;
				dispatch_count <= dispatch_count + 1;
			end
			if (no_bus_check)
				assert (!o_bus_request) else stop_run("Bus request on a fully cached run");
			jump_wait_seen <= waiting;
		end
	end

	task automatic configure(input logic addr, input word_t data);
		i_cfg_write <= 1'b1;
		i_cfg_addr <= addr;
		i_cfg_wdata <= data;
		@(posedge i_clock);
		i_cfg_write <= 1'b0;
	endtask

	task automatic wait_for_transfer();
		int cycles;
		cycles = 0;
		while (!jump_wait_seen) begin
			@(posedge i_clock);
			cycles++;
			if (cycles > wait_limit)
				stop_run("Timeout waiting for a transfer instruction");
		end
	endtask

	task automatic wait_for_dispatch(input int count);
		int cycles;
		cycles = 0;
		while (dispatch_count < count) begin
			@(posedge i_clock);
			cycles++;
			if (cycles > wait_limit)
				stop_run("Timeout waiting for an interrupt dispatch");
		end
	endtask

	// Interrupt pulse goes with the jump, so it is taken before the target loads
	task automatic jump_to(input word_t target, input logic raise_irq);
		int delay;
		delay = $unsigned($random(seed)) % 4;
		repeat (delay) @(posedge i_clock);
		i_jump <= 1'b1;
		i_jump_pc <= target;
		i_irq_line <= raise_irq;
		@(posedge i_clock);
		i_jump <= 1'b0;
		i_irq_line <= 1'b0;
		@(posedge i_clock);
	endtask

	function automatic word_t random_target();
		return word_t'(($unsigned($random(seed)) % 64) * 4);
	endfunction

	initial begin
		int trial;
		int irq_expected;
		word_t target;
		logic irq;
		seed = 32'hdb7aded7;
		bus_wait = -1;
		irq_expected = 0;
		i_clock = 1'b0;
		i_reset = 1'b1;
		i_cfg_write = 1'b0;
		i_cfg_addr = 1'b0;
		i_cfg_wdata = '0;
		i_irq_line = 1'b0;
		i_jump = 1'b0;
		i_jump_pc = '0;
		i_bus_ready = 1'b0;
		i_bus_rdata = '0;
		i_decode_busy = 1'b0;
		jump_wait_seen = 1'b0;
		packet_count = 0;
		dispatch_count = 0;
		irq_allowed = 1'b0;
		no_bus_check = 1'b0;
		repeat (5) @(posedge i_clock);
		i_reset <= 1'b0;
		configure(1'b0, vector_pc);
		configure(1'b1, 32'd1);
		irq_allowed <= 1'b1;

		// Random jumps, about a quarter of them with an interrupt
		for (trial = 0; trial < 40; trial++) begin
			wait_for_transfer();
			target = random_target();
			irq = ($unsigned($random(seed)) % 4) == 0;
			jump_to(target, irq);
			if (irq) begin
				irq_expected++;
				wait_for_dispatch(irq_expected);
			end
		end

		// Enable cleared, the line must be ignored
		configure(1'b1, 32'd0);
		irq_allowed <= 1'b0;
		for (trial = 0; trial < 6; trial++) begin
			wait_for_transfer();
			jump_to(random_target(), 1'b1);
		end

		// Second pass over a run that is already in the cache
		for (trial = 0; trial < 6; trial++) begin
			target = random_target();
			wait_for_transfer();
			jump_to(target, 1'b0);
			wait_for_transfer();
			no_bus_check <= 1'b1;
			jump_to(target, 1'b0);
			wait_for_transfer();
			no_bus_check <= 1'b0;
		end

		if (packet_count > 60 && dispatch_count == irq_expected) begin
			$display("sim passed");
			$finish;
		end else begin
			stop_run("Too few packets or a wrong number of interrupt dispatches");
		end
	end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+.
fetch_pkg.sv
fetch_csr.sv
predecode.sv
icache.sv
fetch_unit.sv
fetch_top.sv
tb_fetch.sv

// ==== Makefile ====
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f compile.f --top-module tb_fetch -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim | tee sim.log
	@if grep -q "sim failed" sim.log || ! grep -q "sim passed" sim.log; then \
		echo "FAIL"; exit 1; \
	else \
		echo "PASS"; \
	fi

clean:
	rm -rf obj_dir sim.log
